//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_frame_parser
FILELIST = sim.f
OBJ_DIR  = obj_dir
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation must run from the project root so the test file is found
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/bridge_pkg.sv
package bridge_pkg;

    // Frame framing and CRC constants
    localparam logic [7:0] SOF_HOST_TO_DEVICE = 8'hA5;
    localparam logic [7:0] CRC8_POLY          = 8'h07;
    localparam int         MAX_DATA_BYTES     = 64;

    typedef logic [5:0] idx_t;   // Payload buffer index
    typedef logic [6:0] count_t; // Wide enough to hold 64

    typedef enum logic [7:0] {
        STATUS_OK      = 8'h00,
        STATUS_CRC_ERR = 8'h01,
        STATUS_CMD_INV = 8'h02,  // Reserved size field
        STATUS_TIMEOUT = 8'h04   // Mid-frame idle
    } status_t;

    typedef enum logic [1:0] {
        SIZE_8    = 2'b00,
        SIZE_16   = 2'b01,
        SIZE_32   = 2'b10,
        SIZE_RSVD = 2'b11
    } xfer_size_t;

    // Command byte as sent on the wire, rw in bit 7
    typedef struct packed {
        logic       rw;   // 1 = read
        logic       inc;
        xfer_size_t size;
        logic [3:0] len;  // Beats minus one
    } cmd_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic       we;
        idx_t       idx;
        logic [7:0] data;
    } data_wr_t;

    typedef struct packed {
        logic        valid;
        status_t     status;
        cmd_t        cmd;
        logic [31:0] addr;
        count_t      count;
    } frame_done_t;

endpackage

//--- rtl/crc8_engine.sv
`timescale 1ns/1ps

module crc8_engine (
    input  logic       clk,
    input  logic       rst,
    input  logic       crc_clear,
    input  logic       crc_update,
    input  logic [7:0] data,
    output logic [7:0] crc
);

    logic [7:0] crc_next;

    // Eight MSB-first shift steps per byte
    always_comb begin
        crc_next = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[7]) begin
                crc_next = {crc_next[6:0], 1'b0} ^ bridge_pkg::CRC8_POLY;
            end else begin
                crc_next = {crc_next[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc <= 8'h00;  // Init value
        end else if (crc_update) begin
            crc <= crc_next;
        end
    end

endmodule

//--- rtl/frame_parser_top.sv
`timescale 1ns/1ps

module frame_parser_top #(
    parameter int CLK_FREQ_HZ        = 125_000_000,
    parameter int BAUD_RATE          = 115_200,
    parameter int TIMEOUT_BYTE_TIMES = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          rx_fifo_data,
    input  logic                rx_fifo_empty,
    output logic                rx_fifo_rd_en,
    input  logic                frame_consumed,
    input  bridge_pkg::idx_t    data_rd_idx,
    output logic                frame_valid,
    output logic                frame_error,
    output bridge_pkg::status_t error_status,
    output bridge_pkg::cmd_t    cmd,
    output logic [31:0]         addr,
    output bridge_pkg::count_t  data_count,
    output logic [7:0]          data_rd_byte,
    output logic                parser_busy
);

    // One UART byte is ten bit times
    localparam int BYTE_TIME_CLOCKS = CLK_FREQ_HZ / (BAUD_RATE / 10);
    localparam int TIMEOUT_CLOCKS   = BYTE_TIME_CLOCKS * TIMEOUT_BYTE_TIMES;

    bridge_pkg::rx_byte_t    rx_byte;
    bridge_pkg::data_wr_t    data_wr;
    bridge_pkg::frame_done_t done;
    logic                    timeout;
    logic                    in_frame;
    logic                    result_held;
    logic                    crc_clear;
    logic                    crc_update;
    logic [7:0]              crc_data;
    logic [7:0]              crc;

    rx_byte_reader #(
        .TIMEOUT_CLOCKS(TIMEOUT_CLOCKS)
    ) u_reader (
        .clk          (clk),
        .rst          (rst),
        .rx_fifo_data (rx_fifo_data),
        .rx_fifo_empty(rx_fifo_empty),
        .in_frame     (in_frame),
        .result_held  (result_held),
        .rx_fifo_rd_en(rx_fifo_rd_en),
        .rx_byte      (rx_byte),
        .timeout      (timeout),
        .parser_busy  (parser_busy)
    );

    crc8_engine u_crc (
        .clk       (clk),
        .rst       (rst),
        .crc_clear (crc_clear),
        .crc_update(crc_update),
        .data      (crc_data),
        .crc       (crc)
    );

    frame_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .rx_byte   (rx_byte),
        .timeout   (timeout),
        .crc       (crc),
        .in_frame  (in_frame),
        .crc_clear (crc_clear),
        .crc_update(crc_update),
        .crc_data  (crc_data),
        .data_wr   (data_wr),
        .done      (done)
    );

    frame_store u_store (
        .clk           (clk),
        .rst           (rst),
        .data_wr       (data_wr),
        .done          (done),
        .frame_consumed(frame_consumed),
        .data_rd_idx   (data_rd_idx),
        .result_held   (result_held),
        .frame_valid   (frame_valid),
        .frame_error   (frame_error),
        .error_status  (error_status),
        .cmd           (cmd),
        .addr          (addr),
        .data_count    (data_count),
        .data_rd_byte  (data_rd_byte)
    );

endmodule

//--- rtl/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  bridge_pkg::rx_byte_t    rx_byte,
    input  logic                    timeout,
    input  logic [7:0]              crc,
    output logic                    in_frame,
    output logic                    crc_clear,
    output logic                    crc_update,
    output logic [7:0]              crc_data,
    output bridge_pkg::data_wr_t    data_wr,
    output bridge_pkg::frame_done_t done
);

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR0,
        ADDR1,
        ADDR2,
        ADDR3,
        DATA,
        CRC
    } state_t;

    state_t              state;
    bridge_pkg::cmd_t    cmd_q;
    logic [31:0]         addr_q;
    bridge_pkg::count_t  byte_cnt;   // Payload bytes taken so far
    bridge_pkg::count_t  len_plus1;
    bridge_pkg::count_t  payload_len;
    logic                is_sof;

    assign len_plus1 = bridge_pkg::count_t'(cmd_q.len) + 1'b1;

    always_comb begin
        case (cmd_q.size)
            bridge_pkg::SIZE_8:  payload_len = len_plus1;
            bridge_pkg::SIZE_16: payload_len = len_plus1 << 1;
            bridge_pkg::SIZE_32: payload_len = len_plus1 << 2;
            default:             payload_len = '0;  // Reserved size has no data
        endcase
    end

    assign is_sof   = rx_byte.data == bridge_pkg::SOF_HOST_TO_DEVICE;
    assign in_frame = state != IDLE;

    // SOF and CRC bytes stay out of the checksum
    assign crc_clear  = rx_byte.valid && state == IDLE && is_sof;
    assign crc_update = rx_byte.valid && state != IDLE && state != CRC;
    assign crc_data   = rx_byte.data;

    assign data_wr.we   = rx_byte.valid && state == DATA;
    assign data_wr.idx  = byte_cnt[5:0];
    assign data_wr.data = rx_byte.data;

    always_comb begin
        done.valid = timeout || (rx_byte.valid && state == CRC);
        done.cmd   = cmd_q;
        done.addr  = addr_q;
        done.count = byte_cnt;
        if (timeout) begin
            done.status = bridge_pkg::STATUS_TIMEOUT;
        end else if (cmd_q.size == bridge_pkg::SIZE_RSVD) begin
            done.status = bridge_pkg::STATUS_CMD_INV;  // Wins over a bad CRC
        end else if (rx_byte.data != crc) begin
            done.status = bridge_pkg::STATUS_CRC_ERR;
        end else begin
            done.status = bridge_pkg::STATUS_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            byte_cnt <= '0;
        end else if (timeout) begin
            state <= IDLE;
        end else if (rx_byte.valid) begin
            case (state)
                IDLE: begin
                    if (is_sof) begin
                        state    <= CMD;
                        byte_cnt <= '0;
                    end
                end
                CMD:   state <= ADDR0;
                ADDR0: state <= ADDR1;
                ADDR1: state <= ADDR2;
                ADDR2: state <= ADDR3;
                ADDR3: begin
                    if (!cmd_q.rw && payload_len != '0) begin
                        state <= DATA;
                    end else begin
                        state <= CRC;  // Read or empty write
                    end
                end
                DATA: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == payload_len - 1'b1) begin
                        state <= CRC;
                    end
                end
                default: state <= IDLE;  // CRC byte closes the frame
            endcase
        end
    end

    // Field capture, little-endian address
    always_ff @(posedge clk) begin
        if (rx_byte.valid) begin
            case (state)
                CMD:     cmd_q        <= bridge_pkg::cmd_t'(rx_byte.data);
                ADDR0:   addr_q[7:0]   <= rx_byte.data;
                ADDR1:   addr_q[15:8]  <= rx_byte.data;
                ADDR2:   addr_q[23:16] <= rx_byte.data;
                ADDR3:   addr_q[31:24] <= rx_byte.data;
                default: ;
            endcase
        end
    end

endmodule

//--- rtl/frame_store.sv
`timescale 1ns/1ps

module frame_store (
    input  logic                    clk,
    input  logic                    rst,
    input  bridge_pkg::data_wr_t    data_wr,
    input  bridge_pkg::frame_done_t done,
    input  logic                    frame_consumed,
    input  bridge_pkg::idx_t        data_rd_idx,
    output logic                    result_held,
    output logic                    frame_valid,
    output logic                    frame_error,
    output bridge_pkg::status_t     error_status,
    output bridge_pkg::cmd_t        cmd,
    output logic [31:0]             addr,
    output bridge_pkg::count_t      data_count,
    output logic [7:0]              data_rd_byte
);

    logic [7:0] data_mem [bridge_pkg::MAX_DATA_BYTES];

    always_ff @(posedge clk) begin
        if (data_wr.we) begin
            data_mem[data_wr.idx] <= data_wr.data;
        end
    end

    assign data_rd_byte = data_mem[data_rd_idx];

    // Held flag; the reader stalls while it is set, so done cannot collide
    always_ff @(posedge clk) begin
        if (rst) begin
            result_held <= 1'b0;
        end else if (done.valid) begin
            result_held <= 1'b1;
        end else if (frame_consumed) begin
            result_held <= 1'b0;
        end
    end

    // Result fields
    always_ff @(posedge clk) begin
        if (done.valid) begin
            error_status <= done.status;
            cmd          <= done.cmd;
            addr         <= done.addr;
            data_count   <= done.count;
        end
    end

    assign frame_valid = result_held && error_status == bridge_pkg::STATUS_OK;
    assign frame_error = result_held && error_status != bridge_pkg::STATUS_OK;

endmodule

//--- rtl/rx_byte_reader.sv
`timescale 1ns/1ps

module rx_byte_reader #(
    parameter int TIMEOUT_CLOCKS = 1000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           rx_fifo_data,
    input  logic                 rx_fifo_empty,
    input  logic                 in_frame,
    input  logic                 result_held,
    output logic                 rx_fifo_rd_en,
    output bridge_pkg::rx_byte_t rx_byte,
    output logic                 timeout,
    output logic                 parser_busy
);

    localparam int CNT_W = $clog2(TIMEOUT_CLOCKS + 1);

    logic [CNT_W-1:0] idle_cnt;

    // Pop as soon as a byte is there, unless the last result is still unread
    assign rx_fifo_rd_en = !rx_fifo_empty && !result_held;

    assign rx_byte.valid = rx_fifo_rd_en;
    assign rx_byte.data  = rx_fifo_data;

    // Fires in the last idle cycle of the window, never together with a pop
    assign timeout = in_frame && !rx_fifo_rd_en &&
                     (idle_cnt == CNT_W'(TIMEOUT_CLOCKS - 1));

    assign parser_busy = in_frame || result_held;

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_cnt <= '0;
        end else if (!in_frame || rx_fifo_rd_en || timeout) begin
            idle_cnt <= '0;  // Watchdog disarmed or rearmed
        end else begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

endmodule

//--- sim.f
rtl/bridge_pkg.sv
rtl/rx_byte_reader.sv
rtl/crc8_engine.sv
rtl/frame_sequencer.sv
rtl/frame_store.sv
rtl/frame_parser_top.sv
verif/clk_gen.sv
verif/frame_parser_chk.sv
verif/tb_frame_parser.sv

//--- verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int HALF_PERIOD_NS = 20  // 40 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

endmodule

//--- verif/frame_parser_chk.sv
`timescale 1ns/1ps

module frame_parser_chk (
    input logic clk,
    input logic rst,
    input logic rx_fifo_empty,
    input logic rx_fifo_rd_en,
    input logic frame_valid,
    input logic frame_error
);

    // A result is either good or bad
    flags_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(frame_valid && frame_error)
    ) else $error("frame_valid and frame_error high together");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst) rx_fifo_rd_en |-> !rx_fifo_empty
    ) else $error("rx_fifo_rd_en high while the FIFO is empty");

    // Held result blocks the FIFO
    no_pop_while_held: assert property (
        @(posedge clk) disable iff (rst) (frame_valid || frame_error) |-> !rx_fifo_rd_en
    ) else $error("rx_fifo_rd_en high while a result is held");

endmodule

bind frame_parser_top frame_parser_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .rx_fifo_empty(rx_fifo_empty),
    .rx_fifo_rd_en(rx_fifo_rd_en),
    .frame_valid  (frame_valid),
    .frame_error  (frame_error)
);

//--- verif/frame_tests.txt
# status(hex) byte_count(dec) bytes(hex, garbage and CRC included) truncated(0/1)
# Write, 32-bit size, LEN 1, eight payload bytes
00 15 A5 61 40 30 20 10 01 02 03 04 05 06 07 08 32 0
# Read preceded by garbage
00 10 00 FF 5A A5 A0 00 10 00 00 51 0
# Bad CRC byte
01 8 A5 00 04 00 00 00 55 24 0
# Good 16-bit write after the bad one
00 9 A5 50 00 01 00 00 AA BB 46 0
# Reserved size code, CRC correct
02 7 A5 32 00 00 00 00 92 0
# Write cut off after two of three payload bytes
04 8 A5 02 00 00 00 00 11 22 1
# Read after the timeout
00 7 A5 83 78 56 34 12 39 0

//--- verif/tb_frame_parser.sv
`timescale 1ns/1ps

module tb_frame_parser;

    logic                clk;
    logic                rst            = 1'b1;
    logic [7:0]          rx_fifo_data   = 8'h00;
    logic                rx_fifo_empty  = 1'b1;
    logic                rx_fifo_rd_en;
    logic                frame_consumed = 1'b0;
    bridge_pkg::idx_t    data_rd_idx    = '0;
    logic                frame_valid;
    logic                frame_error;
    bridge_pkg::status_t error_status;
    bridge_pkg::cmd_t    cmd;
    logic [31:0]         addr;
    bridge_pkg::count_t  data_count;
    logic [7:0]          data_rd_byte;
    logic                parser_busy;

    logic [7:0] fifo_q[$];     // Model of the receive FIFO
    int         pop_count = 0;
    int         seed      = 3063;
    logic [7:0] all_bytes[$];  // Bytes of every record, back to back
    int         rec_start[$];
    int         rec_len[$];
    int         rec_trunc[$];
    logic [7:0] rec_status[$];

    clk_gen u_clk (.clk(clk));

    frame_parser_top #(
        .CLK_FREQ_HZ       (1_000_000),
        .BAUD_RATE         (100_000),
        .TIMEOUT_BYTE_TIMES(2)  // 200 clocks
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .rx_fifo_data  (rx_fifo_data),
        .rx_fifo_empty (rx_fifo_empty),
        .rx_fifo_rd_en (rx_fifo_rd_en),
        .frame_consumed(frame_consumed),
        .data_rd_idx   (data_rd_idx),
        .frame_valid   (frame_valid),
        .frame_error   (frame_error),
        .error_status  (error_status),
        .cmd           (cmd),
        .addr          (addr),
        .data_count    (data_count),
        .data_rd_byte  (data_rd_byte),
        .parser_busy   (parser_busy)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s: expected 0x%0h, got 0x%0h",
                                $time, name, exp, got));
        end
    endtask

    // Head leaves the FIFO on each accepted read
    always @(posedge clk) begin
        if (rx_fifo_rd_en) begin
            if (fifo_q.size() == 0) begin
                abort_run("Read enable seen while the model FIFO is empty");
            end
            void'(fifo_q.pop_front());
            pop_count++;
        end
    end

    always @(negedge clk) begin
        rx_fifo_empty = fifo_q.size() == 0;
        rx_fifo_data  = (fifo_q.size() != 0) ? fifo_q[0] : 8'h00;
    end

    task automatic load_tests();
        int         fd;
        int         rc;
        int         n;
        int         flag;
        string      tok;
        string      rest;
        logic [7:0] b;
        fd = $fopen("verif/frame_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open verif/frame_tests.txt");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                rc = $fgets(rest, fd);  // Skip the comment line
            end else begin
                rc = $sscanf(tok, "%h", b);
                rec_status.push_back(b);
                rc = $fscanf(fd, "%d", n);
                rec_start.push_back(all_bytes.size());
                rec_len.push_back(n);
                repeat (n) begin
                    rc = $fscanf(fd, "%h", b);
                    all_bytes.push_back(b);
                end
                rc = $fscanf(fd, "%d", flag);
                rec_trunc.push_back(flag);
            end
        end
        $fclose(fd);
        if (rec_len.size() == 0) begin
            abort_run("No test records found in verif/frame_tests.txt");
        end
    endtask

    task automatic push_byte(input logic [7:0] b);
        int gap;
        gap = $unsigned($random(seed)) % 6;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        fifo_q.push_back(b);
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (!(frame_valid || frame_error) && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (!(frame_valid || frame_error)) begin
            abort_run("No frame result within 1000 cycles");
        end
    endtask

    task automatic check_result(input int r);
        int          base;
        int          pos;
        int          beat;
        int          n_data;
        int          exp_cnt;
        logic [7:0]  exp_cmd;
        logic [31:0] exp_addr;
        base = rec_start[r];
        pos  = 0;
        while (pos < rec_len[r] && all_bytes[base + pos] != 8'hA5) begin
            pos++;  // Leading garbage
        end
        exp_cmd  = all_bytes[base + pos + 1];
        exp_addr = {all_bytes[base + pos + 5], all_bytes[base + pos + 4],
                    all_bytes[base + pos + 3], all_bytes[base + pos + 2]};
        n_data   = rec_len[r] - (pos + 6) - (rec_trunc[r] != 0 ? 0 : 1);
        case (exp_cmd[5:4])
            2'b00:   beat = 1;
            2'b01:   beat = 2;
            2'b10:   beat = 4;
            default: beat = 0;  // Reserved size
        endcase
        exp_cnt = exp_cmd[7] ? 0 : (int'(exp_cmd[3:0]) + 1) * beat;
        if (n_data < exp_cnt) begin
            exp_cnt = n_data;  // Truncated payload
        end
        compare("frame_valid", 32'(frame_valid), 32'(rec_status[r] == 8'h00));
        compare("frame_error", 32'(frame_error), 32'(rec_status[r] != 8'h00));
        compare("error_status", 32'(error_status), 32'(rec_status[r]));
        compare("cmd", 32'(cmd), 32'(exp_cmd));
        compare("addr", addr, exp_addr);
        compare("data_count", 32'(data_count), exp_cnt);
        for (int i = 0; i < exp_cnt; i++) begin
            data_rd_idx = 6'(i);
            @(negedge clk);
            compare($sformatf("data_rd_byte[%0d]", i), 32'(data_rd_byte),
                    32'(all_bytes[base + pos + 6 + i]));
        end
    endtask

    task automatic consume_result();
        frame_consumed = 1'b1;
        @(negedge clk);
        frame_consumed = 1'b0;
        compare("frame_valid after consume", 32'(frame_valid), 32'd0);
        compare("frame_error after consume", 32'(frame_error), 32'd0);
        compare("parser_busy after consume", 32'(parser_busy), 32'd0);
    endtask

    initial begin
        int pre;
        int pops_before;
        load_tests();
        repeat (10) @(negedge clk);
        compare("rx_fifo_rd_en in reset", 32'(rx_fifo_rd_en), 32'd0);
        compare("frame_valid in reset", 32'(frame_valid), 32'd0);
        compare("frame_error in reset", 32'(frame_error), 32'd0);
        compare("parser_busy in reset", 32'(parser_busy), 32'd0);
        rst = 1'b0;
        pre = 0;
        for (int r = 0; r < rec_len.size(); r++) begin
            for (int i = pre; i < rec_len[r]; i++) begin
                push_byte(all_bytes[rec_start[r] + i]);
            end
            @(negedge clk);
            // Last byte still waits in the FIFO, frame in progress
            compare("parser_busy in frame", 32'(parser_busy), 32'd1);
            wait_result();
            check_result(r);
            pre = 0;
            if (r + 1 < rec_len.size()) begin
                // Next frame's first bytes queue up behind the held result
                pre = (rec_len[r + 1] < 3) ? rec_len[r + 1] : 3;
                pops_before = pop_count;
                for (int i = 0; i < pre; i++) begin
                    @(posedge clk);
                    fifo_q.push_back(all_bytes[rec_start[r + 1] + i]);
                end
                repeat (20) @(negedge clk);
                compare("pop count while held", pop_count, pops_before);
                compare("FIFO level while held", fifo_q.size(), pre);
                compare("result flag while held", 32'(frame_valid || frame_error), 32'd1);
                compare("parser_busy while held", 32'(parser_busy), 32'd1);
            end
            consume_result();
        end
        compare("total bytes popped", pop_count, all_bytes.size());
        $display("All tests passed!");
        $finish;
    end

endmodule
